/* cpuPkg.sv */
package cpuPkg;

	// Bus and storage sizes
	localparam int WordWidth = 16;
	localparam int RegCount = 16;
	localparam int RegAddrWidth = 4;
	localparam int MemDepth = 256;
	localparam int MemAddrWidth = 8;
	localparam int OpWidth = 4;
	localparam int ImmWidth = 8;

	// Instruction fields
	localparam int OpMsb = 15;
	localparam int OpLsb = 12;
	localparam int DstMsb = 11;
	localparam int DstLsb = 8;
	localparam int SrcMsb = 7;
	localparam int SrcLsb = 4;
	localparam int ImmMsb = 7;
	localparam int ImmLsb = 0;

	// Opcodes
	localparam logic [OpWidth-1:0] OpNop = 4'd0;
	localparam logic [OpWidth-1:0] OpAdd = 4'd1;
	localparam logic [OpWidth-1:0] OpSub = 4'd2;
	localparam logic [OpWidth-1:0] OpAnd = 4'd3;
	localparam logic [OpWidth-1:0] OpOr = 4'd4;
	localparam logic [OpWidth-1:0] OpXor = 4'd5;
	localparam logic [OpWidth-1:0] OpShr = 4'd6;
	localparam logic [OpWidth-1:0] OpMov = 4'd7;
	localparam logic [OpWidth-1:0] OpLdi = 4'd8;
	localparam logic [OpWidth-1:0] OpLd = 4'd9;
	localparam logic [OpWidth-1:0] OpSt = 4'd10;
	localparam logic [OpWidth-1:0] OpJmp = 4'd11;
	localparam logic [OpWidth-1:0] OpJz = 4'd12;
	localparam logic [OpWidth-1:0] OpJc = 4'd13;
	localparam logic [OpWidth-1:0] OpJr = 4'd14;
	localparam logic [OpWidth-1:0] OpHalt = 4'd15;

	// Next-PC select
	localparam int NextPcSelWidth = 2;
	localparam logic [NextPcSelWidth-1:0] NextPcIncr = 2'd0;
	localparam logic [NextPcSelWidth-1:0] NextPcImm = 2'd1;
	localparam logic [NextPcSelWidth-1:0] NextPcReg = 2'd2;

	// Sequencer states
	localparam int StateWidth = 2;
	localparam logic [StateWidth-1:0] StateFetch = 2'd0;
	localparam logic [StateWidth-1:0] StateExec = 2'd1;
	localparam logic [StateWidth-1:0] StateHalted = 2'd2;

endpackage

/* registerFile.sv */
`timescale 1ns/1ps

module registerFile (
	input  logic clk,
	input  logic rst,
	input  logic we,
	input  logic [cpuPkg::RegAddrWidth-1:0] writeIdx,
	input  logic [cpuPkg::RegAddrWidth-1:0] dstIdx,
	input  logic [cpuPkg::RegAddrWidth-1:0] srcIdx,
	input  logic [cpuPkg::WordWidth-1:0] writeData,
	output logic [cpuPkg::WordWidth-1:0] dstData,
	output logic [cpuPkg::WordWidth-1:0] srcData
);

	logic [cpuPkg::WordWidth-1:0] regs [cpuPkg::RegCount];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < cpuPkg::RegCount; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[writeIdx] <= writeData;
		end
	end

	// Reads see the value before this edge's write
	assign dstData = regs[dstIdx];
	assign srcData = regs[srcIdx];

endmodule

/* alu.sv */
`timescale 1ns/1ps

module alu (
	input  logic clk,
	input  logic rst,
	input  logic [cpuPkg::OpWidth-1:0] op,
	input  logic [cpuPkg::WordWidth-1:0] a,
	input  logic [cpuPkg::WordWidth-1:0] b,
	input  logic flagWe,
	output logic [cpuPkg::WordWidth-1:0] result,
	output logic carry,
	output logic zero
);

	logic [cpuPkg::WordWidth:0] sum;
	logic [cpuPkg::WordWidth:0] diff;
	logic nextCarry;

	// Extra top bit holds carry-out or borrow
	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};

	always_comb begin
		result = b;
		nextCarry = 1'b0;
		case (op)
			cpuPkg::OpAdd: begin
				result = sum[cpuPkg::WordWidth-1:0];
				nextCarry = sum[cpuPkg::WordWidth];
			end
			cpuPkg::OpSub: begin
				result = diff[cpuPkg::WordWidth-1:0];
				nextCarry = diff[cpuPkg::WordWidth];
			end
			cpuPkg::OpAnd: begin
				result = a & b;
			end
			cpuPkg::OpOr: begin
				result = a | b;
			end
			cpuPkg::OpXor: begin
				result = a ^ b;
			end
			cpuPkg::OpShr: begin
				result = b >> 1;
				nextCarry = b[0];
			end
			cpuPkg::OpMov: begin
				result = b;
			end
			default: begin
				result = b;
			end
		endcase
	end

	// Flags change only on the decoder's request
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			carry <= 1'b0;
			zero <= 1'b0;
		end else if (flagWe) begin
			carry <= nextCarry;
			zero <= (result == '0);
		end
	end

endmodule

/* decoder.sv */
`timescale 1ns/1ps

module decoder (
	input  logic [cpuPkg::WordWidth-1:0] instr,
	input  logic execStrobe,
	input  logic carry,
	input  logic zero,
	output logic [cpuPkg::OpWidth-1:0] aluOp,
	output logic [cpuPkg::RegAddrWidth-1:0] dstIdx,
	output logic [cpuPkg::RegAddrWidth-1:0] srcIdx,
	output logic [cpuPkg::WordWidth-1:0] instrData,
	output logic regWe,
	output logic memWe,
	output logic flagWe,
	output logic immSel,
	output logic memSel,
	output logic halt,
	output logic [cpuPkg::NextPcSelWidth-1:0] nextPcSel
);

	logic [cpuPkg::OpWidth-1:0] opcode;
	logic regCond;
	logic memCond;
	logic flagCond;
	logic haltCond;

	assign opcode = instr[cpuPkg::OpMsb:cpuPkg::OpLsb];
	assign aluOp = opcode;
	assign dstIdx = instr[cpuPkg::DstMsb:cpuPkg::DstLsb];
	assign srcIdx = instr[cpuPkg::SrcMsb:cpuPkg::SrcLsb];
	assign instrData = {{(cpuPkg::WordWidth - cpuPkg::ImmWidth){1'b0}},
		instr[cpuPkg::ImmMsb:cpuPkg::ImmLsb]};

	always_comb begin
		regCond = 1'b0;
		memCond = 1'b0;
		flagCond = 1'b0;
		haltCond = 1'b0;
		immSel = 1'b0;
		memSel = 1'b0;
		nextPcSel = cpuPkg::NextPcIncr;
		case (opcode)
			cpuPkg::OpNop: begin
			end
			cpuPkg::OpAdd, cpuPkg::OpSub, cpuPkg::OpAnd,
			cpuPkg::OpOr, cpuPkg::OpXor, cpuPkg::OpShr: begin
				regCond = 1'b1;
				flagCond = 1'b1;
			end
			cpuPkg::OpMov: begin
				regCond = 1'b1;
			end
			cpuPkg::OpLdi: begin
				regCond = 1'b1;
				immSel = 1'b1;
			end
			cpuPkg::OpLd: begin
				regCond = 1'b1;
				memSel = 1'b1;
			end
			cpuPkg::OpSt: begin
				memCond = 1'b1;
			end
			cpuPkg::OpJmp: begin
				nextPcSel = cpuPkg::NextPcImm;
			end
			// Conditional jumps fall through to pc+1 when the flag is clear
			cpuPkg::OpJz: begin
				if (zero) begin
					nextPcSel = cpuPkg::NextPcImm;
				end
			end
			cpuPkg::OpJc: begin
				if (carry) begin
					nextPcSel = cpuPkg::NextPcImm;
				end
			end
			cpuPkg::OpJr: begin
				nextPcSel = cpuPkg::NextPcReg;
			end
			cpuPkg::OpHalt: begin
				haltCond = 1'b1;
			end
			default: begin
			end
		endcase
	end

	// Side effects only in the execute cycle
	assign regWe = regCond & execStrobe;
	assign memWe = memCond & execStrobe;
	assign flagWe = flagCond & execStrobe;
	assign halt = haltCond & execStrobe;

endmodule

/* processor.sv */
`timescale 1ns/1ps

module processor (
	input  logic clk,
	input  logic rst,
	input  logic [cpuPkg::WordWidth-1:0] readData,
	output logic [cpuPkg::WordWidth-1:0] addrBus,
	output logic [cpuPkg::WordWidth-1:0] writeData,
	output logic memWe,
	output logic halted
);

	logic [cpuPkg::StateWidth-1:0] state;
	logic [cpuPkg::WordWidth-1:0] pc;
	logic [cpuPkg::WordWidth-1:0] nextPc;
	logic [cpuPkg::WordWidth-1:0] instr;
	logic execStrobe;

	logic [cpuPkg::OpWidth-1:0] aluOp;
	logic [cpuPkg::RegAddrWidth-1:0] dstIdx;
	logic [cpuPkg::RegAddrWidth-1:0] srcIdx;
	logic [cpuPkg::WordWidth-1:0] dstData;
	logic [cpuPkg::WordWidth-1:0] srcData;
	logic [cpuPkg::WordWidth-1:0] instrData;
	logic [cpuPkg::WordWidth-1:0] aluResult;
	logic [cpuPkg::WordWidth-1:0] writeBack;
	logic [cpuPkg::NextPcSelWidth-1:0] nextPcSel;
	logic regWe;
	logic flagWe;
	logic immSel;
	logic memSel;
	logic halt;
	logic carry;
	logic zero;

	registerFile regFile_i (
		.clk(clk),
		.rst(rst),
		.we(regWe),
		.writeIdx(dstIdx),
		.dstIdx(dstIdx),
		.srcIdx(srcIdx),
		.writeData(writeBack),
		.dstData(dstData),
		.srcData(srcData)
	);

	alu alu_i (
		.clk(clk),
		.rst(rst),
		.op(aluOp),
		.a(dstData),
		.b(srcData),
		.flagWe(flagWe),
		.result(aluResult),
		.carry(carry),
		.zero(zero)
	);

	decoder decoder_i (
		.instr(instr),
		.execStrobe(execStrobe),
		.carry(carry),
		.zero(zero),
		.aluOp(aluOp),
		.dstIdx(dstIdx),
		.srcIdx(srcIdx),
		.instrData(instrData),
		.regWe(regWe),
		.memWe(memWe),
		.flagWe(flagWe),
		.immSel(immSel),
		.memSel(memSel),
		.halt(halt),
		.nextPcSel(nextPcSel)
	);

	always_comb begin
		case (nextPcSel)
			cpuPkg::NextPcImm: nextPc = instrData;
			cpuPkg::NextPcReg: nextPc = srcData;
			default: nextPc = pc + 1'b1;
		endcase
	end

	// Data address only while executing LD or ST
	assign addrBus = memWe ? dstData : ((execStrobe && memSel) ? srcData : pc);
	assign writeData = srcData;
	assign writeBack = immSel ? instrData : (memSel ? readData : aluResult);
	assign halted = (state == cpuPkg::StateHalted);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= cpuPkg::StateFetch;
			pc <= '0;
			execStrobe <= 1'b0;
		end else begin
			execStrobe <= 1'b0;
			case (state)
				cpuPkg::StateFetch: begin
					execStrobe <= 1'b1;
					state <= cpuPkg::StateExec;
				end
				cpuPkg::StateExec: begin
					if (halt) begin
						state <= cpuPkg::StateHalted;
					end else begin
						pc <= nextPc;
						state <= cpuPkg::StateFetch;
					end
				end
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == cpuPkg::StateFetch) begin
			instr <= readData;
		end
	end

endmodule

/* dataMemory.sv */
`timescale 1ns/1ps

module dataMemory (
	input  logic clk,
	input  logic [cpuPkg::WordWidth-1:0] cpuAddr,
	input  logic cpuWe,
	input  logic [cpuPkg::WordWidth-1:0] cpuWriteData,
	output logic [cpuPkg::WordWidth-1:0] cpuReadData,
	input  logic loadWe,
	input  logic [cpuPkg::MemAddrWidth-1:0] loadAddr,
	input  logic [cpuPkg::WordWidth-1:0] loadData,
	input  logic [cpuPkg::MemAddrWidth-1:0] peekAddr,
	output logic [cpuPkg::WordWidth-1:0] peekData
);

	logic [cpuPkg::WordWidth-1:0] mem [cpuPkg::MemDepth];
	logic [cpuPkg::MemAddrWidth-1:0] cpuIdx;

	// Upper address bits are ignored
	assign cpuIdx = cpuAddr[cpuPkg::MemAddrWidth-1:0];

	// Processor write has priority over the load port
	always_ff @(posedge clk) begin
		if (cpuWe) begin
			mem[cpuIdx] <= cpuWriteData;
		end else if (loadWe) begin
			mem[loadAddr] <= loadData;
		end
	end

	assign cpuReadData = mem[cpuIdx];
	assign peekData = mem[peekAddr];

endmodule

/* processorTop.sv */
`timescale 1ns/1ps

module processorTop (
	input  logic clk,
	input  logic rst,
	input  logic loadWe,
	input  logic [cpuPkg::MemAddrWidth-1:0] loadAddr,
	input  logic [cpuPkg::WordWidth-1:0] loadData,
	input  logic [cpuPkg::MemAddrWidth-1:0] peekAddr,
	output logic [cpuPkg::WordWidth-1:0] peekData,
	output logic halted
);

	logic [cpuPkg::WordWidth-1:0] addrBus;
	logic [cpuPkg::WordWidth-1:0] writeData;
	logic [cpuPkg::WordWidth-1:0] readData;
	logic memWe;

	processor processor_i (
		.clk(clk),
		.rst(rst),
		.readData(readData),
		.addrBus(addrBus),
		.writeData(writeData),
		.memWe(memWe),
		.halted(halted)
	);

	dataMemory dataMemory_i (
		.clk(clk),
		.cpuAddr(addrBus),
		.cpuWe(memWe),
		.cpuWriteData(writeData),
		.cpuReadData(readData),
		.loadWe(loadWe),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.peekAddr(peekAddr),
		.peekData(peekData)
	);

endmodule

/* processorTb.sv */
`timescale 1ns/1ps

module processorTb;

	localparam int FileWords = 1024;
	localparam int ResetCycles = 8;
	localparam int RunCycles = 512;

	logic clk;
	logic rst;
	logic loadWe;
	logic [cpuPkg::MemAddrWidth-1:0] loadAddr;
	logic [cpuPkg::WordWidth-1:0] loadData;
	logic [cpuPkg::MemAddrWidth-1:0] peekAddr;
	logic [cpuPkg::WordWidth-1:0] peekData;
	logic halted;

	logic [cpuPkg::WordWidth-1:0] testWords [FileWords];
	int cycleCount;
	int cycleLimit;

	processorTop dut_i (
		.clk(clk),
		.rst(rst),
		.loadWe(loadWe),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.peekAddr(peekAddr),
		.peekData(peekData),
		.halted(halted)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("timeout: program did not halt within %0d cycles", cycleLimit);
			$display("SOME TESTS FAILED");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	task automatic checkValue(input string name, input logic [cpuPkg::WordWidth-1:0] actual,
		input logic [cpuPkg::WordWidth-1:0] expected);
		if (actual !== expected) begin
			$display("mismatch at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("SOME TESTS FAILED");
			$fatal(1, "stopped at the first failed check");
		end
	endtask

	// Walks the records: count, words, check count, address/value pairs
	function automatic int countTests();
		int idx;
		int tests;
		idx = 0;
		tests = 0;
		while (idx < FileWords && !$isunknown(testWords[idx]) && testWords[idx] != '0) begin
			tests++;
			idx = idx + 1 + int'(testWords[idx]);
			idx = idx + 1 + 2 * int'(testWords[idx]);
		end
		return tests;
	endfunction

	// Whole memory is written, zeros past the program
	task automatic loadProgram(input int start, input int count);
		for (int addr = 0; addr < cpuPkg::MemDepth; addr++) begin
			@(negedge clk);
			loadWe = 1'b1;
			loadAddr = addr[cpuPkg::MemAddrWidth-1:0];
			loadData = (addr < count) ? testWords[start + addr] : '0;
		end
		@(negedge clk);
		loadWe = 1'b0;
	endtask

	task automatic waitForHalt();
		@(negedge clk);
		while (!halted) begin
			@(negedge clk);
		end
	endtask

	task automatic peekAndCheck(input logic [cpuPkg::MemAddrWidth-1:0] addr,
		input logic [cpuPkg::WordWidth-1:0] expected);
		@(negedge clk);
		peekAddr = addr;
		@(posedge clk);
		checkValue($sformatf("peekData[%02h]", addr), peekData, expected);
	endtask

	initial begin
		int idx;
		int testNum;
		int wordCount;
		int checkCount;
		clk = 1'b0;
		rst = 1'b1;
		loadWe = 1'b0;
		loadAddr = '0;
		loadData = '0;
		peekAddr = '0;
		cycleCount = 0;
		cycleLimit = 0;
		$readmemh("cpuTests.mem", testWords);
		testNum = countTests();
		if (testNum == 0) begin
			$display("error: cpuTests.mem holds no test records");
			$display("SOME TESTS FAILED");
			$fatal(1, "nothing to run");
		end
		cycleLimit = testNum * (ResetCycles + cpuPkg::MemDepth + RunCycles);
		idx = 0;
		for (int t = 0; t < testNum; t++) begin
			wordCount = int'(testWords[idx]);
			@(negedge clk);
			rst = 1'b1;
			repeat (ResetCycles) @(negedge clk);
			// Reset stays high through the load
			loadProgram(idx + 1, wordCount);
			// Reset leaves the halted state
			checkValue("halted", halted, 1'b0);
			rst = 1'b0;
			idx = idx + 1 + wordCount;
			checkCount = int'(testWords[idx]);
			idx++;
			waitForHalt();
			for (int c = 0; c < checkCount; c++) begin
				peekAndCheck(testWords[idx][cpuPkg::MemAddrWidth-1:0], testWords[idx + 1]);
				idx += 2;
			end
			// Halted holds until the next reset
			@(negedge clk);
			checkValue("halted", halted, 1'b1);
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* cpuTests.mem */
// Record: word count N (hex), N program words from address 0,
// check count M (hex), then M pairs of memory address and expected value
// LDI then ST of two immediates
0007
8180 82AB A120 8481 83FF A430 F000
0002
0080 00AB 0081 00FF
// Immediate halt leaves memory as loaded
0004
F000 1234 5678 9ABC
0005
0000 F000 0001 1234 0002 5678 0003 9ABC
0004 0000
// ALU results with 16-bit wraparound
0023
8101 8F40 8200 2210 AF20 1F10 8302 1320 AF30 1F10
84F0 853C 7640 3650 AF60 1F10 7640 4650 AF60 1F10
7640 5650 AF60 1F10 6720 AF70 1F10 7820 AF80 1F10
8905 8A07 29A0 AF90 F000
0008
0040 FFFF 0041 0001 0042 0030 0043 00FC
0044 00CC 0045 7FFF 0046 FFFF 0047 FFFE
// JZ and JC taken and not taken, MOV keeps flags, XOR clears carry
002D
8E50 8105 8205 2120 C007 83EE B008 8311 AE30 7420
D00D 8322 B00E 83DD 8E51 AE30 C013 83CC B014 8333
8E52 AE30 8501 8600 2650 D01C 83BB B01D 8344 8E53
AE30 C022 8355 B023 83AA 8E54 AE30 5660 D029 8366
B02A 8399 8E55 AE30 F000
0006
0050 0011 0051 0022 0052 0033
0053 0044 0054 0055 0055 0066
// LD of a loaded word, store and load round trip
000D
810C 9210 8360 A320 8461 6520 A450 9640 8762 A760
F000 0000 BEEF
0004
0060 BEEF 0061 5F77 0062 5F77 000C BEEF
// Countdown loop with JMP and JR, ends with both flags set
0011
8105 8301 8200 8406 B006 82FF 1210 2130 C00A E040
8570 A520 8671 A610 8701 6770 F000
0003
0070 000F 0071 0000 0005 82FF
// After reset registers and flags read as zero
000B
810A A120 C006 D006 8377 B007 83EE 8181 A130 F000
5555
0002
000A 0000 0081 0077
// End of records
0000

/* all.f */
cpuPkg.sv
registerFile.sv
alu.sv
decoder.sv
processor.sv
dataMemory.sv
processorTop.sv
processorTb.sv

/* Makefile */
TOP ?= processorTb
SEED ?= 7
LOG ?= sim.log
FILELIST ?= all.f
OBJDIR ?= obj_dir
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	-$(OBJDIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
